//--- lsu_macros.svh
// LSU configuration
// datapath widths, RAM depth, pipe depths and exception cause codes
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// datapath and address space
`define LSU_XLEN            64
`define LSU_SV              39

// tightly coupled data RAM, in 64-bit words
`define LSU_RAM_DEPTH       64

// scoreboard tag
`define LSU_TRANS_ID_BITS   3

// output register depths
`define LSU_LOAD_PIPE_REGS  1
`define LSU_STORE_PIPE_REGS 1

// RISC-V exception causes
`define LSU_CAUSE_LD_MISALIGNED 6'd4
`define LSU_CAUSE_LD_ACCESS     6'd5
`define LSU_CAUSE_ST_MISALIGNED 6'd6
`define LSU_CAUSE_ST_ACCESS     6'd7

`endif

//--- lsu_pkg.sv
// LSU shared types
// operation codes, pipeline records and operator classification
`include "lsu_macros.svh"

package lsu_pkg;

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    // NOP sits at zero so a cleared record decodes as idle
    typedef enum logic [3:0] {
        NOP = 4'd0,
        LB  = 4'd1,
        LH  = 4'd2,
        LW  = 4'd3,
        LD  = 4'd4,
        LBU = 4'd5,
        LHU = 4'd6,
        LWU = 4'd7,
        SB  = 4'd8,
        SH  = 4'd9,
        SW  = 4'd10,
        SD  = 4'd11
    } lsu_op_e;

    // word index into the data RAM
    typedef logic [$clog2(`LSU_RAM_DEPTH)-1:0] ram_addr_t;

    // ------------------------------------------------------------
    // pipeline records
    // ------------------------------------------------------------
    typedef struct packed {
        lsu_op_e                       operator;
        logic [`LSU_XLEN-1:0]          operand_a;
        logic [`LSU_XLEN-1:0]          operand_b;
        logic [`LSU_XLEN-1:0]          imm;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    typedef struct packed {
        logic                          valid;
        logic [`LSU_XLEN-1:0]          vaddr;
        logic                          overflow;
        logic [`LSU_XLEN-1:0]          wdata;
        logic [`LSU_XLEN/8-1:0]        be;
        lsu_op_e                       operator;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
    } lsu_ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [5:0]           cause;
        logic [`LSU_XLEN-1:0] tval;
    } exception_t;

    typedef struct packed {
        logic                          valid;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
        logic [`LSU_XLEN-1:0]          result;
        exception_t                    ex;
    } load_resp_t;

    typedef struct packed {
        logic                          valid;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
        exception_t                    ex;
    } store_resp_t;

    // ------------------------------------------------------------
    // operator helpers
    // ------------------------------------------------------------
    function automatic logic is_load(lsu_op_e op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    // log2 of the access size in bytes
    function automatic logic [1:0] op_size(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 2'd0;
            LH, LHU, SH: return 2'd1;
            LW, LWU, SW: return 2'd2;
            default:     return 2'd3;
        endcase
    endfunction

endpackage

//--- lsu_pipe_reg.sv
// generic output pipeline register
// resettable shift register of depth stages over any packed payload
`timescale 1ns/1ps

module lsu_pipe_reg #(
    parameter type         payload_t = logic,
    parameter int unsigned depth     = 1
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  payload_t d_i,
    output payload_t d_o
);

    if (depth == 0) begin : gen_pass
        assign d_o = d_i;
    end else begin : gen_regs
        payload_t q [depth];

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                for (int i = 0; i < depth; i++) begin
                    q[i] <= '0;
                end
            end else begin
                q[0] <= d_i;
                for (int i = 1; i < depth; i++) begin
                    q[i] <= q[i-1];
                end
            end
        end

        assign d_o = q[depth-1];
    end

endmodule

//--- lsu_agu.sv
// LSU address generation unit
// computes the effective address, Sv39 overflow flag and byte enables, then registers them
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_agu import lsu_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      valid_i,
    input  fu_data_t  fu_data_i,
    output lsu_ctrl_t ctrl_o
);

    logic [`LSU_XLEN-1:0]   vaddr;
    logic                   overflow;
    logic [`LSU_XLEN/8-1:0] be;
    lsu_ctrl_t              ctrl_d;

    // mask of size bytes, moved up to the byte offset
    function automatic logic [`LSU_XLEN/8-1:0] be_gen(logic [2:0] offset, logic [1:0] size);
        logic [`LSU_XLEN/8-1:0] mask;
        case (size)
            2'd0:    mask = 8'h01;
            2'd1:    mask = 8'h03;
            2'd2:    mask = 8'h0f;
            default: mask = 8'hff;
        endcase
        return mask << offset;
    endfunction

    // ------------------------------------------------------------
    // address and overflow
    // ------------------------------------------------------------
    assign vaddr = $unsigned($signed(fu_data_i.operand_a) + $signed(fu_data_i.imm));

    // upper bits must be a sign extension of bit 38
    assign overflow = !((&vaddr[`LSU_XLEN-1:`LSU_SV-1]) || !(|vaddr[`LSU_XLEN-1:`LSU_SV-1]));

    assign be = be_gen(vaddr[2:0], op_size(fu_data_i.operator));

    always_comb begin
        ctrl_d.valid    = valid_i;
        ctrl_d.vaddr    = vaddr;
        ctrl_d.overflow = overflow;
        ctrl_d.wdata    = fu_data_i.operand_b;
        ctrl_d.be       = be;
        ctrl_d.operator = fu_data_i.operator;
        ctrl_d.trans_id = fu_data_i.trans_id;
    end

    // ------------------------------------------------------------
    // stage 1 register
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ctrl_o <= '0;
        end else begin
            ctrl_o <= ctrl_d;
        end
    end

endmodule

//--- lsu_except_check.sv
// LSU exception check
// flags misaligned and out-of-range accesses and routes the op to load or store
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_except_check import lsu_pkg::*; (
    input  lsu_ctrl_t  ctrl_i,
    input  logic       en_ld_st_translation_i,
    output logic       ld_valid_o,
    output logic       st_valid_o,
    output exception_t ex_o
);

    logic is_ld;
    logic is_st;
    logic misaligned;

    assign is_ld = is_load(ctrl_i.operator);
    assign is_st = ctrl_i.operator inside {SB, SH, SW, SD};

    // routing by operator
    assign ld_valid_o = ctrl_i.valid && is_ld;
    assign st_valid_o = ctrl_i.valid && is_st;

    // ------------------------------------------------------------
    // misalignment
    // ------------------------------------------------------------
    always_comb begin
        case (op_size(ctrl_i.operator))
            2'd3:    misaligned = (ctrl_i.vaddr[2:0] != 3'b000);
            2'd2:    misaligned = (ctrl_i.vaddr[1:0] != 2'b00);
            2'd1:    misaligned = ctrl_i.vaddr[0];
            // bytes are always aligned
            default: misaligned = 1'b0;
        endcase
    end

    // ------------------------------------------------------------
    // exception record
    // ------------------------------------------------------------
    always_comb begin
        ex_o       = '0;
        ex_o.tval  = ctrl_i.vaddr;

        if (ld_valid_o || st_valid_o) begin
            if (misaligned) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_ld ? `LSU_CAUSE_LD_MISALIGNED : `LSU_CAUSE_ST_MISALIGNED;
            end
            // access fault wins over misalignment
            if (en_ld_st_translation_i && ctrl_i.overflow) begin
                ex_o.valid = 1'b1;
                ex_o.cause = is_ld ? `LSU_CAUSE_LD_ACCESS : `LSU_CAUSE_ST_ACCESS;
            end
        end

        if (!ex_o.valid) begin
            ex_o.tval = '0;
        end
    end

endmodule

//--- lsu_data_ram.sv
// LSU data RAM
// 64-bit words with byte-masked write and registered read
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_data_ram import lsu_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   we_i,
    input  logic [`LSU_XLEN/8-1:0] be_i,
    input  ram_addr_t              waddr_i,
    input  logic [`LSU_XLEN-1:0]   wdata_i,
    input  logic                   re_i,
    input  ram_addr_t              raddr_i,
    output logic [`LSU_XLEN-1:0]   rdata_o
);

    logic [`LSU_XLEN-1:0] mem [`LSU_RAM_DEPTH];

    // same-word read and write returns the old word
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < `LSU_RAM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata_o <= '0;
        end else begin
            if (re_i) begin
                rdata_o <= mem[raddr_i];
            end
            if (we_i) begin
                for (int b = 0; b < `LSU_XLEN/8; b++) begin
                    if (be_i[b]) begin
                        mem[waddr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

//--- lsu_store_unit.sv
// LSU store unit
// aligns store data to its byte lanes, writes the RAM and forms the store response
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_store_unit import lsu_pkg::*; (
    input  lsu_ctrl_t              ctrl_i,
    input  logic                   valid_i,
    input  exception_t             ex_i,
    output logic                   ram_we_o,
    output logic [`LSU_XLEN/8-1:0] ram_be_o,
    output ram_addr_t              ram_addr_o,
    output logic [`LSU_XLEN-1:0]   ram_wdata_o,
    output store_resp_t            resp_o
);

    logic [5:0] lane_shift;

    // byte offset in bits
    assign lane_shift = {ctrl_i.vaddr[2:0], 3'b000};

    // ------------------------------------------------------------
    // RAM write port
    // ------------------------------------------------------------
    // faulting stores leave memory alone
    assign ram_we_o    = valid_i && !ex_i.valid;
    assign ram_be_o    = ctrl_i.be;
    assign ram_addr_o  = ctrl_i.vaddr[3 +: $bits(ram_addr_t)];
    assign ram_wdata_o = ctrl_i.wdata << lane_shift;

    // ------------------------------------------------------------
    // response
    // ------------------------------------------------------------
    always_comb begin
        resp_o.valid    = valid_i;
        resp_o.trans_id = ctrl_i.trans_id;
        resp_o.ex       = ex_i;
    end

endmodule

//--- lsu_load_unit.sv
// LSU load unit
// issues RAM reads, then extracts and extends the loaded value into the load response
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_load_unit import lsu_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  lsu_ctrl_t            ctrl_i,
    input  logic                 valid_i,
    input  exception_t           ex_i,
    output logic                 ram_re_o,
    output ram_addr_t            ram_addr_o,
    input  logic [`LSU_XLEN-1:0] ram_rdata_i,
    output load_resp_t           resp_o
);

    // what travels alongside the RAM read
    typedef struct packed {
        logic                          valid;
        logic [2:0]                    offset;
        lsu_op_e                       operator;
        logic [`LSU_TRANS_ID_BITS-1:0] trans_id;
        exception_t                    ex;
    } ld_state_t;

    ld_state_t            state_q;
    logic [`LSU_XLEN-1:0] shifted;
    logic [`LSU_XLEN-1:0] extended;

    // ------------------------------------------------------------
    // read request
    // ------------------------------------------------------------
    assign ram_re_o   = valid_i && !ex_i.valid;
    assign ram_addr_o = ctrl_i.vaddr[3 +: $bits(ram_addr_t)];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= '0;
        end else begin
            state_q.valid    <= valid_i;
            state_q.offset   <= ctrl_i.vaddr[2:0];
            state_q.operator <= ctrl_i.operator;
            state_q.trans_id <= ctrl_i.trans_id;
            state_q.ex       <= ex_i;
        end
    end

    // ------------------------------------------------------------
    // data extraction
    // ------------------------------------------------------------
    assign shifted = ram_rdata_i >> {state_q.offset, 3'b000};

    always_comb begin
        case (state_q.operator)
            LB:      extended = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
            LH:      extended = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
            LW:      extended = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
            LBU:     extended = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
            LHU:     extended = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
            LWU:     extended = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
            default: extended = shifted;
        endcase
    end

    always_comb begin
        resp_o.valid    = state_q.valid;
        resp_o.trans_id = state_q.trans_id;
        resp_o.ex       = state_q.ex;
        // faulting loads return zero
        resp_o.result   = (state_q.valid && !state_q.ex.valid) ? extended : '0;
    end

endmodule

//--- load_store_unit.sv
// load/store unit top
// AGU, exception check, load and store paths around a tightly coupled data RAM
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_store_unit import lsu_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        lsu_valid_i,
    input  fu_data_t    fu_data_i,
    input  logic        en_ld_st_translation_i,
    output load_resp_t  load_resp_o,
    output store_resp_t store_resp_o
);

    lsu_ctrl_t              ctrl;
    logic                   ld_valid;
    logic                   st_valid;
    exception_t             ex;

    logic                   ram_we;
    logic [`LSU_XLEN/8-1:0] ram_be;
    ram_addr_t              ram_waddr;
    logic [`LSU_XLEN-1:0]   ram_wdata;
    logic                   ram_re;
    ram_addr_t              ram_raddr;
    logic [`LSU_XLEN-1:0]   ram_rdata;

    load_resp_t             ld_resp;
    store_resp_t            st_resp;

    // ------------------------------------------------------------
    // stage 1 and routing
    // ------------------------------------------------------------
    lsu_agu i_agu (
        .clk_i     ( clk_i       ),
        .rst_ni    ( rst_ni      ),
        .valid_i   ( lsu_valid_i ),
        .fu_data_i ( fu_data_i   ),
        .ctrl_o    ( ctrl        )
    );

    lsu_except_check i_except_check (
        .ctrl_i                 ( ctrl                   ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .ld_valid_o             ( ld_valid               ),
        .st_valid_o             ( st_valid               ),
        .ex_o                   ( ex                     )
    );

    // ------------------------------------------------------------
    // memory paths
    // ------------------------------------------------------------
    lsu_store_unit i_store_unit (
        .ctrl_i      ( ctrl      ),
        .valid_i     ( st_valid  ),
        .ex_i        ( ex        ),
        .ram_we_o    ( ram_we    ),
        .ram_be_o    ( ram_be    ),
        .ram_addr_o  ( ram_waddr ),
        .ram_wdata_o ( ram_wdata ),
        .resp_o      ( st_resp   )
    );

    lsu_load_unit i_load_unit (
        .clk_i       ( clk_i     ),
        .rst_ni      ( rst_ni    ),
        .ctrl_i      ( ctrl      ),
        .valid_i     ( ld_valid  ),
        .ex_i        ( ex        ),
        .ram_re_o    ( ram_re    ),
        .ram_addr_o  ( ram_raddr ),
        .ram_rdata_i ( ram_rdata ),
        .resp_o      ( ld_resp   )
    );

    lsu_data_ram i_data_ram (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .we_i    ( ram_we    ),
        .be_i    ( ram_be    ),
        .waddr_i ( ram_waddr ),
        .wdata_i ( ram_wdata ),
        .re_i    ( ram_re    ),
        .raddr_i ( ram_raddr ),
        .rdata_o ( ram_rdata )
    );

    // ------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------
    lsu_pipe_reg #(
        .payload_t ( load_resp_t          ),
        .depth     ( `LSU_LOAD_PIPE_REGS  )
    ) i_pipe_reg_load (
        .clk_i  ( clk_i       ),
        .rst_ni ( rst_ni      ),
        .d_i    ( ld_resp     ),
        .d_o    ( load_resp_o )
    );

    lsu_pipe_reg #(
        .payload_t ( store_resp_t         ),
        .depth     ( `LSU_STORE_PIPE_REGS )
    ) i_pipe_reg_store (
        .clk_i  ( clk_i        ),
        .rst_ni ( rst_ni       ),
        .d_i    ( st_resp      ),
        .d_o    ( store_resp_o )
    );

endmodule

//--- tb_load_store_unit.sv
// load/store unit testbench
// random ops from an xorshift stream, checked against a shadow memory model
`timescale 1ns/1ps
`include "lsu_macros.svh"

module tb_load_store_unit import lsu_pkg::*; ();

    localparam int NUM_OPS        = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 2 + 50;

    logic        clk_i;
    logic        rst_ni;
    logic        lsu_valid_i;
    fu_data_t    fu_data_i;
    logic        en_ld_st_translation_i;
    load_resp_t  load_resp_o;
    store_resp_t store_resp_o;

    logic [`LSU_XLEN-1:0]          shadow_mem [`LSU_RAM_DEPTH];
    logic [63:0]                   rng_state;
    logic [`LSU_TRANS_ID_BITS-1:0] next_tid;
    logic [5:0]                    last_store_idx;
    int                            cycle = 0;
    int                            load_errors;
    int                            store_errors;
    int                            other_errors;

    // expected responses with the cycle they are due in
    load_resp_t  exp_load_q [$];
    int          load_cyc_q [$];
    store_resp_t exp_store_q [$];
    int          store_cyc_q [$];

    load_store_unit i_dut (
        .clk_i                  ( clk_i                  ),
        .rst_ni                 ( rst_ni                 ),
        .lsu_valid_i            ( lsu_valid_i            ),
        .fu_data_i              ( fu_data_i              ),
        .en_ld_st_translation_i ( en_ld_st_translation_i ),
        .load_resp_o            ( load_resp_o            ),
        .store_resp_o           ( store_resp_o           )
    );

    initial clk_i = 1'b0;
    always #10 clk_i = ~clk_i;

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    function automatic int size_bytes(lsu_op_e op);
        case (op)
            LB, LBU, SB: return 1;
            LH, LHU, SH: return 2;
            LW, LWU, SW: return 4;
            default:     return 8;
        endcase
    endfunction

    function automatic bit reads_memory(lsu_op_e op);
        return op inside {LB, LH, LW, LD, LBU, LHU, LWU};
    endfunction

    // random op, mostly aligned with some misaligned or with bad upper bits
    task automatic make_op(output fu_data_t op, output bit en);
        logic [63:0] r;
        logic [63:0] r2;
        logic [63:0] vaddr;
        logic [63:0] imm;
        lsu_op_e     operator;
        int          size;
        logic [5:0]  idx;
        logic [2:0]  off;
        r        = next_rand();
        r2       = next_rand();
        operator = lsu_op_e'(r[3:0] % 11 + 1);
        size     = size_bytes(operator);
        // half of the ops reuse the word of the last store
        idx      = r[4] ? last_store_idx : r[10:5];
        off      = r[13:11] & ~3'(size - 1);
        if (r[16:14] == 3'd0) begin
            off = off | 3'd1;
        end
        vaddr = {{26{r[19]}}, r[48:20], idx, off};
        if (r[52:50] == 3'd0) begin
            vaddr[`LSU_SV - 1 + int'(r[60:53] % 26)] ^= 1'b1;
        end
        imm            = {{52{r2[11]}}, r2[11:0]};
        op.operator    = operator;
        op.imm         = imm;
        op.operand_a   = vaddr - imm;
        op.operand_b   = next_rand();
        op.trans_id    = next_tid;
        next_tid       = next_tid + 1'b1;
        en             = r[62] | r[61];
        if (!reads_memory(operator)) begin
            last_store_idx = idx;
        end
    endtask

    // ------------------------------------------------------------
    // reference model, applied at issue in program order
    // ------------------------------------------------------------
    task automatic apply_op(input fu_data_t op, input bit en, input int issue_cycle);
        logic [63:0] vaddr;
        logic [63:0] value;
        int          size;
        int          idx;
        int          off;
        bit          overflow;
        bit          is_ld;
        exception_t  ex;
        load_resp_t  lr;
        store_resp_t sr;
        vaddr    = op.operand_a + op.imm;
        size     = size_bytes(op.operator);
        is_ld    = reads_memory(op.operator);
        idx      = vaddr[8:3];
        off      = vaddr[2:0];
        overflow = !(vaddr[63:38] == '0 || vaddr[63:38] == '1);
        ex       = '0;
        if (en && overflow) begin
            ex.valid = 1'b1;
            ex.cause = is_ld ? `LSU_CAUSE_LD_ACCESS : `LSU_CAUSE_ST_ACCESS;
            ex.tval  = vaddr;
        end else if ((off % size) != 0) begin
            ex.valid = 1'b1;
            ex.cause = is_ld ? `LSU_CAUSE_LD_MISALIGNED : `LSU_CAUSE_ST_MISALIGNED;
            ex.tval  = vaddr;
        end
        if (is_ld) begin
            value = '0;
            if (!ex.valid) begin
                for (int b = 0; b < size; b++) begin
                    value[b*8 +: 8] = shadow_mem[idx][(off + b)*8 +: 8];
                end
                if (op.operator inside {LB, LH, LW} && value[size*8 - 1]) begin
                    value = value | (~64'd0 << (size * 8));
                end
            end
            lr.valid    = 1'b1;
            lr.trans_id = op.trans_id;
            lr.result   = value;
            lr.ex       = ex;
            exp_load_q.push_back(lr);
            load_cyc_q.push_back(issue_cycle + 3);
        end else begin
            if (!ex.valid) begin
                for (int b = 0; b < size; b++) begin
                    shadow_mem[idx][(off + b)*8 +: 8] = op.operand_b[b*8 +: 8];
                end
            end
            sr.valid    = 1'b1;
            sr.trans_id = op.trans_id;
            sr.ex       = ex;
            exp_store_q.push_back(sr);
            store_cyc_q.push_back(issue_cycle + 2);
        end
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp, inout int errs);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errs++;
        end
    endtask

    task automatic check_load(input load_resp_t got);
        load_resp_t exp;
        int         exp_cycle;
        if (exp_load_q.size() == 0) begin
            $display("Load response at %0t while no load was outstanding", $time);
            other_errors++;
            return;
        end
        exp       = exp_load_q.pop_front();
        exp_cycle = load_cyc_q.pop_front();
        compare_field("load_resp_o arrival cycle", cycle, exp_cycle, load_errors);
        compare_field("load_resp_o.trans_id", got.trans_id, exp.trans_id, load_errors);
        compare_field("load_resp_o.result", got.result, exp.result, load_errors);
        compare_field("load_resp_o.ex.valid", got.ex.valid, exp.ex.valid, load_errors);
        compare_field("load_resp_o.ex.cause", got.ex.cause, exp.ex.cause, load_errors);
        compare_field("load_resp_o.ex.tval", got.ex.tval, exp.ex.tval, load_errors);
    endtask

    task automatic check_store(input store_resp_t got);
        store_resp_t exp;
        int          exp_cycle;
        if (exp_store_q.size() == 0) begin
            $display("Store response at %0t while no store was outstanding", $time);
            other_errors++;
            return;
        end
        exp       = exp_store_q.pop_front();
        exp_cycle = store_cyc_q.pop_front();
        compare_field("store_resp_o arrival cycle", cycle, exp_cycle, store_errors);
        compare_field("store_resp_o.trans_id", got.trans_id, exp.trans_id, store_errors);
        compare_field("store_resp_o.ex.valid", got.ex.valid, exp.ex.valid, store_errors);
        compare_field("store_resp_o.ex.cause", got.ex.cause, exp.ex.cause, store_errors);
        compare_field("store_resp_o.ex.tval", got.ex.tval, exp.ex.tval, store_errors);
    endtask

    // ------------------------------------------------------------
    // monitor and timeout
    // ------------------------------------------------------------
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (load_resp_o.valid) begin
                check_load(load_resp_o);
            end
            if (store_resp_o.valid) begin
                check_store(store_resp_o);
            end
        end
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, %0d loads and %0d stores still outstanding",
                     cycle, exp_load_q.size(), exp_store_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    initial begin
        fu_data_t    op;
        bit          en_op;
        bit          en_next;
        logic [63:0] r;
        int          issued;
        lsu_valid_i            = 1'b0;
        fu_data_i              = '0;
        en_ld_st_translation_i = 1'b0;
        rst_ni                 = 1'b0;
        rng_state              = 64'd64;
        next_tid               = '0;
        last_store_idx         = '0;
        load_errors            = 0;
        store_errors           = 0;
        other_errors           = 0;
        en_next                = 1'b0;
        issued                 = 0;
        for (int i = 0; i < `LSU_RAM_DEPTH; i++) begin
            shadow_mem[i] = '0;
        end

        repeat (4) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        // idle after reset so any stray response gets flagged
        repeat (5) @(posedge clk_i);

        while (issued < NUM_OPS) begin
            @(posedge clk_i);
            #2;
            // the enable is seen by the exception check one cycle after issue
            en_ld_st_translation_i = en_next;
            r = next_rand();
            if (r[3:0] < 4'd3) begin
                lsu_valid_i         = 1'b0;
                fu_data_i.operand_a = r;
                en_next             = r[4];
            end else begin
                make_op(op, en_op);
                lsu_valid_i = 1'b1;
                fu_data_i   = op;
                en_next     = en_op;
                apply_op(op, en_op, cycle);
                issued++;
            end
        end
        @(posedge clk_i);
        #2;
        lsu_valid_i            = 1'b0;
        en_ld_st_translation_i = en_next;

        // longest response latency is three cycles after issue
        repeat (3) @(posedge clk_i);

        if (exp_load_q.size() != 0 || exp_store_q.size() != 0) begin
            $display("Responses missing at the end of the run");
            other_errors++;
        end
        $display("Error counts: load %0d, store %0d, other %0d",
                 load_errors, store_errors, other_errors);
        if (load_errors == 0 && store_errors == 0 && other_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- all.f
+incdir+.
lsu_pkg.sv
lsu_pipe_reg.sv
lsu_agu.sv
lsu_except_check.sv
lsu_data_ram.sv
lsu_store_unit.sv
lsu_load_unit.sv
load_store_unit.sv
tb_load_store_unit.sv

//--- Bender.yml
package:
  name: load_store_unit

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - lsu_pkg.sv
      - lsu_pipe_reg.sv
      - lsu_agu.sv
      - lsu_except_check.sv
      - lsu_data_ram.sv
      - lsu_store_unit.sv
      - lsu_load_unit.sv
      - load_store_unit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_load_store_unit.sv
